// ==== Bender.yml ====
package:
  name: cache_l2

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/lc3b_types.sv
      - rtl/l2_if.sv
      - rtl/l2_slave_port.sv
      - rtl/cache_datapath_l2.sv
      - rtl/cache_control_l2.sv
      - rtl/l2_pmem_master.sv
      - rtl/cache_l2_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - testbench/pmem_model.sv
      - testbench/tb_cache_l2.sv

// ==== flist.f ====
+incdir+rtl
rtl/lc3b_types.sv
rtl/l2_if.sv
rtl/l2_slave_port.sv
rtl/cache_datapath_l2.sv
rtl/cache_control_l2.sv
rtl/l2_pmem_master.sv
rtl/cache_l2_top.sv
testbench/pmem_model.sv
testbench/tb_cache_l2.sv

// ==== rtl/cache_control_l2.sv ====
module cache_control_l2 import lc3b_types::*; (
	input logic clk,
	input logic reset,
	l2_req_if.ctrl req,
	l2_mem_if.ctrl mem,
	output logic load_data,
	output logic load_valid,
	output logic load_dirty,
	output logic clear_dirty,
	output logic load_lru,
	output logic load_tag,
	output logic cache_in_sel,
	output logic pmem_addr_sel,
	input logic tag_hit,
	input logic dirty
);

	l2_state_t state;
	l2_state_t next_state;
	logic issued;                  // Memory transfer already started.
	logic install;                 // Whole line goes into the LRU way.

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
			issued <= 1'b0;
		end else begin
			state <= next_state;
			if (mem.start)
				issued <= 1'b1;
			else if (mem.done)
				issued <= 1'b0;
		end
	end

	// Start once on entry to a memory state.
	assign mem.start = (state == write_back || state == allocate) && !issued;
	assign mem.we = (state == write_back);
	assign pmem_addr_sel = (state == write_back);
	assign req.done = (state == respond);

	// Write miss on a clean way, or after the victim is out.
	assign install = req.we && !tag_hit &&
		((state == compare && !dirty) || (state == write_back && mem.done));

	always_comb begin
		next_state = state;
		load_data = 1'b0;
		load_valid = 1'b0;
		load_dirty = 1'b0;
		clear_dirty = 1'b0;
		load_lru = 1'b0;
		load_tag = 1'b0;
		cache_in_sel = req.we;
		case (state)
			idle: begin
				if (req.req)
					next_state = compare;
			end
			compare: begin
				if (tag_hit) begin
					load_lru = 1'b1;
					load_data = req.we;         // Write hit updates in place.
					load_dirty = req.we;
					next_state = respond;
				end else if (dirty) begin
					next_state = write_back;
				end else if (!req.we) begin
					next_state = allocate;
				end
			end
			write_back: begin
				if (mem.done)
					next_state = req.we ? respond : allocate;
			end
			allocate: begin
				if (mem.done) begin
					load_data = 1'b1;
					load_tag = 1'b1;
					load_valid = 1'b1;
					clear_dirty = 1'b1;
					load_lru = 1'b1;
					next_state = respond;
				end
			end
			respond: next_state = idle;
			default: next_state = idle;
		endcase
		if (install) begin
			load_data = 1'b1;
			load_tag = 1'b1;
			load_valid = 1'b1;
			load_dirty = 1'b1;
			load_lru = 1'b1;
			next_state = respond;
		end
	end

	// Only from a memory state and only for a pending request that missed.
	start_in_mem_state: assert property (@(posedge clk) disable iff (reset)
		mem.start |-> ((state == write_back || state == allocate) && req.req && !tag_hit));

endmodule : cache_control_l2

// ==== rtl/cache_datapath_l2.sv ====
`include "l2_params.svh"

module cache_datapath_l2 import lc3b_types::*; (
	input logic clk,
	input logic reset,
	l2_req_if.dp req,
	l2_mem_if.dp mem,
	input logic load_data,
	input logic load_valid,
	input logic load_dirty,
	input logic clear_dirty,
	input logic load_lru,
	input logic load_tag,
	input logic cache_in_sel,      // 1 picks the L1 line, 0 the memory line.
	input logic pmem_addr_sel,     // 1 picks the victim, 0 the request line.
	output logic tag_hit,
	output logic dirty
);

	// ****************************************
	// Storage
	// ****************************************

	lc3b_burst data0 [`L2_NUM_SETS];
	lc3b_burst data1 [`L2_NUM_SETS];
	lc3b_tag_l2 tags0 [`L2_NUM_SETS];
	lc3b_tag_l2 tags1 [`L2_NUM_SETS];
	logic [`L2_NUM_SETS-1:0] valid0;
	logic [`L2_NUM_SETS-1:0] valid1;
	logic [`L2_NUM_SETS-1:0] dirty0;
	logic [`L2_NUM_SETS-1:0] dirty1;
	logic [`L2_NUM_SETS-1:0] lru;  // Way to replace next.

	lc3b_tag_l2 req_tag;
	lc3b_set_l2 set;
	lc3b_tag_l2 way_tag;
	lc3b_burst line_in;
	lc3b_burst line_out;
	logic hit0;
	logic hit1;
	logic way_sel;                 // Way being read or written.

	// ****************************************
	// Lookup
	// ****************************************

	assign req_tag = req.addr[`L2_OFFSET_W+`L2_SET_W +: `L2_TAG_W];
	assign set = req.addr[`L2_OFFSET_W +: `L2_SET_W];

	assign hit0 = valid0[set] && (tags0[set] == req_tag);
	assign hit1 = valid1[set] && (tags1[set] == req_tag);
	assign tag_hit = hit0 || hit1;

	// Hit way, else the LRU way.
	assign way_sel = tag_hit ? hit1 : lru[set];

	assign dirty = lru[set] ? dirty1[set] : dirty0[set];   // Victim state.

	assign line_out = way_sel ? data1[set] : data0[set];
	assign way_tag = way_sel ? tags1[set] : tags0[set];
	assign line_in = cache_in_sel ? req.wdata : mem.rdata;

	assign req.rdata = line_out;
	assign mem.wdata = line_out;   // Victim line on write-back.

	// Victim line address or the request's own line.
	assign mem.addr = pmem_addr_sel ? {way_tag, set, {`L2_OFFSET_W{1'b0}}}
		: {req.addr[`L2_OFFSET_W+`L2_SET_W+`L2_TAG_W-1:`L2_OFFSET_W],
			{`L2_OFFSET_W{1'b0}}};

	// ****************************************
	// Array updates
	// ****************************************

	always_ff @(posedge clk) begin
		if (load_data) begin
			if (way_sel)
				data1[set] <= line_in;
			else
				data0[set] <= line_in;
		end
		if (load_tag) begin
			if (way_sel)
				tags1[set] <= req_tag;
			else
				tags0[set] <= req_tag;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid0 <= '0;
			valid1 <= '0;
			dirty0 <= '0;
			dirty1 <= '0;
			lru <= '0;
		end else begin
			if (load_valid) begin
				if (way_sel)
					valid1[set] <= 1'b1;
				else
					valid0[set] <= 1'b1;
			end
			if (load_dirty || clear_dirty) begin
				if (way_sel)
					dirty1[set] <= load_dirty;
				else
					dirty0[set] <= load_dirty;
			end
			if (load_lru)
				lru[set] <= ~way_sel;               // Point at the other way.
		end
	end

	// A tag is installed only into a way that missed.
	single_way_hit: assert property (@(posedge clk) disable iff (reset)
		!$isunknown(set) |-> !(hit0 && hit1));

endmodule : cache_datapath_l2

// ==== rtl/cache_l2_top.sv ====
module cache_l2_top import lc3b_types::*; (
	input logic clk,
	input logic reset,
	input logic l1_cyc,
	input logic l1_stb,
	input logic l1_we,
	input lc3b_word l1_adr,
	input lc3b_burst l1_dat_w,
	output lc3b_burst l1_dat_r,
	output logic l1_ack,
	output logic pmem_cyc,
	output logic pmem_stb,
	output logic pmem_we,
	output lc3b_word pmem_adr,
	output lc3b_burst pmem_dat_w,
	input lc3b_burst pmem_dat_r,
	input logic pmem_ack
);

	l2_req_if req_if ();
	l2_mem_if mem_if ();

	logic load_data;
	logic load_valid;
	logic load_dirty;
	logic clear_dirty;
	logic load_lru;
	logic load_tag;
	logic cache_in_sel;
	logic pmem_addr_sel;
	logic tag_hit;
	logic dirty;

	l2_slave_port u_slave_port (
		.clk(clk),
		.reset(reset),
		.l1_cyc(l1_cyc),
		.l1_stb(l1_stb),
		.l1_we(l1_we),
		.l1_adr(l1_adr),
		.l1_dat_w(l1_dat_w),
		.l1_dat_r(l1_dat_r),
		.l1_ack(l1_ack),
		.req(req_if.port)
	);

	cache_datapath_l2 u_datapath (
		.clk(clk),
		.reset(reset),
		.req(req_if.dp),
		.mem(mem_if.dp),
		.load_data(load_data),
		.load_valid(load_valid),
		.load_dirty(load_dirty),
		.clear_dirty(clear_dirty),
		.load_lru(load_lru),
		.load_tag(load_tag),
		.cache_in_sel(cache_in_sel),
		.pmem_addr_sel(pmem_addr_sel),
		.tag_hit(tag_hit),
		.dirty(dirty)
	);

	cache_control_l2 u_control (
		.clk(clk),
		.reset(reset),
		.req(req_if.ctrl),
		.mem(mem_if.ctrl),
		.load_data(load_data),
		.load_valid(load_valid),
		.load_dirty(load_dirty),
		.clear_dirty(clear_dirty),
		.load_lru(load_lru),
		.load_tag(load_tag),
		.cache_in_sel(cache_in_sel),
		.pmem_addr_sel(pmem_addr_sel),
		.tag_hit(tag_hit),
		.dirty(dirty)
	);

	l2_pmem_master u_pmem_master (
		.clk(clk),
		.reset(reset),
		.mem(mem_if.master),
		.pmem_cyc(pmem_cyc),
		.pmem_stb(pmem_stb),
		.pmem_we(pmem_we),
		.pmem_adr(pmem_adr),
		.pmem_dat_w(pmem_dat_w),
		.pmem_dat_r(pmem_dat_r),
		.pmem_ack(pmem_ack)
	);

endmodule : cache_l2_top

// ==== rtl/l2_if.sv ====
// Request from the slave port to the cache core.
interface l2_req_if import lc3b_types::*; ();
	logic req;          // Held until done.
	logic we;
	lc3b_word addr;
	lc3b_burst wdata;
	lc3b_burst rdata;   // Valid with done.
	logic done;

	modport port (output req, we, addr, wdata, input rdata, done);
	modport dp (input addr, wdata, output rdata);
	modport ctrl (input req, we, output done);
endinterface : l2_req_if

// One line transfer from the cache core to the memory master.
interface l2_mem_if import lc3b_types::*; ();
	logic start;        // Single cycle pulse.
	logic we;
	lc3b_word addr;     // Line aligned.
	lc3b_burst wdata;
	lc3b_burst rdata;   // Valid with done.
	logic done;

	modport ctrl (output start, we, input done);
	modport dp (output addr, wdata, input rdata);
	modport master (input start, we, addr, wdata, output rdata, done);
endinterface : l2_mem_if

// ==== rtl/l2_params.svh ====
`ifndef L2_PARAMS_SVH
`define L2_PARAMS_SVH

// ****************************************
// Address split of the L2 cache
// ****************************************

`define L2_TAG_W 7          // Tag bits 15 to 9.
`define L2_SET_W 5          // Set index bits 8 to 4.
`define L2_OFFSET_W 4       // Byte offset within a line.

// ****************************************
// Array geometry
// ****************************************

`define L2_LINE_W 128       // One line, 16 bytes.
`define L2_NUM_SETS 32      // Sets per way.

`endif

// ==== rtl/l2_pmem_master.sv ====
module l2_pmem_master import lc3b_types::*; (
	input logic clk,
	input logic reset,
	l2_mem_if.master mem,
	output logic pmem_cyc,
	output logic pmem_stb,
	output logic pmem_we,
	output lc3b_word pmem_adr,
	output lc3b_burst pmem_dat_w,
	input lc3b_burst pmem_dat_r,
	input logic pmem_ack
);

	logic busy;                    // Bus cycle open.

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			mem.done <= 1'b0;
		end else begin
			mem.done <= busy && pmem_ack;           // Cycle after ack.
			if (mem.start)
				busy <= 1'b1;
			else if (pmem_ack)
				busy <= 1'b0;
		end
	end

	// Transfer fields and returned line.
	always_ff @(posedge clk) begin
		if (mem.start) begin
			pmem_we <= mem.we;
			pmem_adr <= mem.addr;
			pmem_dat_w <= mem.wdata;
		end
		if (busy && pmem_ack)
			mem.rdata <= pmem_dat_r;
	end

	assign pmem_cyc = busy;
	assign pmem_stb = busy;

	// Request held steady until the ack.
	stb_until_ack: assert property (@(posedge clk) disable iff (reset)
		(pmem_stb && !pmem_ack) |=> (pmem_stb && $stable(pmem_adr) && $stable(pmem_we)));

endmodule : l2_pmem_master

// ==== rtl/l2_slave_port.sv ====
module l2_slave_port import lc3b_types::*; (
	input logic clk,
	input logic reset,
	input logic l1_cyc,
	input logic l1_stb,
	input logic l1_we,
	input lc3b_word l1_adr,
	input lc3b_burst l1_dat_w,
	output lc3b_burst l1_dat_r,
	output logic l1_ack,
	l2_req_if.port req
);

	logic port_free;    // Neither holding a request nor acking.

	assign port_free = !req.req && !l1_ack;

	// Request flag and ack pulse.
	always_ff @(posedge clk) begin
		if (reset) begin
			req.req <= 1'b0;
			l1_ack <= 1'b0;
		end else begin
			l1_ack <= req.done;                     // One cycle after done.
			if (port_free && l1_cyc && l1_stb)
				req.req <= 1'b1;
			else if (req.done)
				req.req <= 1'b0;
		end
	end

	// Captured request fields, held while the core works.
	always_ff @(posedge clk) begin
		if (port_free && l1_cyc && l1_stb) begin
			req.we <= l1_we;
			req.addr <= l1_adr;
			req.wdata <= l1_dat_w;
		end
		if (req.done)
			l1_dat_r <= req.rdata;                  // Line returned to L1.
	end

	// The L1 master keeps its strobe up until it sees the ack.
	ack_inside_cycle: assert property (@(posedge clk) disable iff (reset)
		l1_ack |-> (l1_cyc && l1_stb));

endmodule : l2_slave_port

// ==== rtl/lc3b_types.sv ====
`include "l2_params.svh"

package lc3b_types;

	// ****************************************
	// Address and data types
	// ****************************************

	// Full byte address.
	typedef logic [`L2_TAG_W+`L2_SET_W+`L2_OFFSET_W-1:0] lc3b_word;

	typedef logic [`L2_LINE_W-1:0] lc3b_burst;     // Whole cache line.

	typedef logic [`L2_TAG_W-1:0] lc3b_tag_l2;     // Stored tag.

	typedef logic [`L2_SET_W-1:0] lc3b_set_l2;     // Set index.

	// ****************************************
	// Controller states
	// ****************************************

	typedef enum logic [2:0] {
		idle,           // Waiting for a request.
		compare,        // Tag lookup.
		write_back,     // Dirty victim out to memory.
		allocate,       // Line fetch from memory.
		respond         // Done pulse to the slave port.
	} l2_state_t;

endpackage : lc3b_types

// ==== testbench/pmem_model.sv ====
`include "l2_params.svh"

module pmem_model import lc3b_types::*; (
	input logic clk,
	input logic reset,
	input logic cyc,
	input logic stb,
	input logic we,
	input lc3b_word adr,
	input lc3b_burst dat_w,
	output lc3b_burst dat_r,
	output logic ack
);

	localparam int NUM_LINES = 1 << (`L2_TAG_W + `L2_SET_W);
	localparam int WAIT_CYCLES = 2;

	lc3b_burst lines [NUM_LINES];
	logic [`L2_TAG_W+`L2_SET_W-1:0] index;
	int wait_count;
	int read_count;
	int write_count;
	lc3b_word last_write_adr;
	lc3b_burst last_write_dat;

	assign index = adr[`L2_OFFSET_W +: `L2_TAG_W+`L2_SET_W];

	// Each line holds its own byte address eight times.
	initial begin
		for (int i = 0; i < NUM_LINES; i++)
			lines[i] = {(`L2_LINE_W/16){lc3b_word'(i << `L2_OFFSET_W)}};
	end

	always @(posedge clk) begin
		if (reset) begin
			ack <= 1'b0;
			wait_count <= 0;
			read_count <= 0;
			write_count <= 0;
		end else begin
			ack <= 1'b0;                                // Single cycle ack.
			if (cyc && stb && !ack) begin
				if (wait_count == WAIT_CYCLES) begin
					wait_count <= 0;
					ack <= 1'b1;
					if (we) begin
						lines[index] <= dat_w;
						write_count <= write_count + 1;
						last_write_adr <= adr;
						last_write_dat <= dat_w;
					end else begin
						dat_r <= lines[index];
						read_count <= read_count + 1;
					end
				end else begin
					wait_count <= wait_count + 1;
				end
			end
		end
	end

endmodule : pmem_model

// ==== testbench/tb_cache_l2.sv ====
`include "l2_params.svh"

module tb_cache_l2 import lc3b_types::*; ();

	localparam int NUM_LINES = 1 << (`L2_TAG_W + `L2_SET_W);
	localparam int RANDOM_COUNT = 32;
	localparam int NUM_REQUESTS = 18 + RANDOM_COUNT;
	localparam int REQ_CYCLES = 40;                     // Worst miss plus margin.

	logic clk;
	logic reset;
	logic l1_cyc;
	logic l1_stb;
	logic l1_we;
	lc3b_word l1_adr;
	lc3b_burst l1_dat_w;
	lc3b_burst l1_dat_r;
	logic l1_ack;
	logic pmem_cyc;
	logic pmem_stb;
	logic pmem_we;
	lc3b_word pmem_adr;
	lc3b_burst pmem_dat_w;
	lc3b_burst pmem_dat_r;
	logic pmem_ack;

	lc3b_burst shadow [NUM_LINES];                      // Expected line contents.
	logic [31:0] lfsr_state;
	int errors;
	int checks;
	int test_errors;
	int tests_run;

	cache_l2_top u_cache_l2_top (
		.clk(clk),
		.reset(reset),
		.l1_cyc(l1_cyc),
		.l1_stb(l1_stb),
		.l1_we(l1_we),
		.l1_adr(l1_adr),
		.l1_dat_w(l1_dat_w),
		.l1_dat_r(l1_dat_r),
		.l1_ack(l1_ack),
		.pmem_cyc(pmem_cyc),
		.pmem_stb(pmem_stb),
		.pmem_we(pmem_we),
		.pmem_adr(pmem_adr),
		.pmem_dat_w(pmem_dat_w),
		.pmem_dat_r(pmem_dat_r),
		.pmem_ack(pmem_ack)
	);

	pmem_model u_pmem (
		.clk(clk),
		.reset(reset),
		.cyc(pmem_cyc),
		.stb(pmem_stb),
		.we(pmem_we),
		.adr(pmem_adr),
		.dat_w(pmem_dat_w),
		.dat_r(pmem_dat_r),
		.ack(pmem_ack)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Bound covers reset and every request at its worst latency.
	initial begin
		#((10 + NUM_REQUESTS * (REQ_CYCLES + 2)) * 10);
		$display("watchdog: the run did not finish within the request bound");
		$display("TEST RESULT: FAIL");
		$finish;
	end

	// ****************************************
	// Helpers
	// ****************************************

	function automatic lc3b_word line_addr(input lc3b_tag_l2 tag, input lc3b_set_l2 set);
		return {tag, set, {`L2_OFFSET_W{1'b0}}};
	endfunction

	function automatic int line_index(input lc3b_word addr);
		return int'(addr[`L2_OFFSET_W +: `L2_TAG_W+`L2_SET_W]);
	endfunction

	function automatic lc3b_burst initial_line(input lc3b_word addr);
		return {(`L2_LINE_W/16){addr}};
	endfunction

	// Taps 32, 22, 2, 1.
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_bits(input int n, output lc3b_burst value);
		value = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = {value[`L2_LINE_W-2:0], lfsr_state[0]};
		end
	endtask

	task automatic compare_value(input string name, input lc3b_burst expected,
		input lc3b_burst actual);
		checks++;
		assert (actual === expected) else begin
			$display("error: %s expected %0h actual %0h", name, expected, actual);
			test_errors++;
		end
	endtask

	task automatic require(input logic cond, input string what);
		checks++;
		assert (cond) else begin
			$display("%s", what);
			test_errors++;
		end
	endtask

	task automatic finish_test(input string name);
		if (test_errors == 0)
			$display("test %s: passed", name);
		else
			$display("test %s: failed with %0d errors", name, test_errors);
		errors += test_errors;
		test_errors = 0;
		tests_run++;
	endtask

	// One classic cycle as the L1 master; cycles counts edges up to the ack.
	task automatic l1_transfer(input logic we, input lc3b_word addr, input lc3b_burst wdata,
		output lc3b_burst rdata, output int cycles);
		@(posedge clk);
		#1;
		l1_cyc = 1'b1;
		l1_stb = 1'b1;
		l1_we = we;
		l1_adr = addr;
		l1_dat_w = wdata;
		cycles = 0;
		do begin
			@(posedge clk);
			#1;
			cycles++;
		end while (!l1_ack && cycles < REQ_CYCLES);
		rdata = l1_dat_r;
		require(l1_ack, "the cache gave no ack within the request bound");
		@(posedge clk);                                 // Strobe held through the ack cycle.
		#1;
		l1_cyc = 1'b0;
		l1_stb = 1'b0;
		l1_we = 1'b0;
	endtask

	task automatic read_and_check(input string name, input lc3b_word addr, output int cycles);
		lc3b_burst rdata;
		l1_transfer(1'b0, addr, '0, rdata, cycles);
		compare_value(name, shadow[line_index(addr)], rdata);
	endtask

	task automatic write_line(input lc3b_word addr, input lc3b_burst data);
		lc3b_burst rdata;
		int cycles;
		l1_transfer(1'b1, addr, data, rdata, cycles);
		shadow[line_index(addr)] = data;
	endtask

	// ****************************************
	// Directed tests
	// ****************************************

	task automatic test_reset();
		int reads_before;
		int writes_before;
		int cycles;
		require(!l1_ack, "l1_ack is high after reset");
		require(!pmem_cyc, "pmem_cyc is high after reset");
		require(!pmem_stb, "pmem_stb is high after reset");
		reads_before = u_pmem.read_count;
		writes_before = u_pmem.write_count;
		read_and_check("reset", line_addr(7'd1, 5'd0), cycles);
		compare_value("reset", reads_before + 1, u_pmem.read_count);
		compare_value("reset", writes_before, u_pmem.write_count);
		finish_test("reset");
	endtask

	task automatic test_read_hit();
		lc3b_word addr;
		int reads_before;
		int writes_before;
		int cycles;
		addr = line_addr(7'd2, 5'd1);
		reads_before = u_pmem.read_count;
		writes_before = u_pmem.write_count;
		read_and_check("read_hit", addr, cycles);
		compare_value("read_hit", reads_before + 1, u_pmem.read_count);
		read_and_check("read_hit", addr, cycles);
		compare_value("read_hit", reads_before + 1, u_pmem.read_count);
		compare_value("read_hit", writes_before, u_pmem.write_count);
		compare_value("read_hit", 4, cycles);           // Strobe to ack on a hit.
		finish_test("read_hit");
	endtask

	task automatic test_write_hit();
		lc3b_word addr;
		lc3b_burst data;
		int writes_before;
		int cycles;
		addr = line_addr(7'd3, 5'd2);
		writes_before = u_pmem.write_count;
		read_and_check("write_hit", addr, cycles);
		draw_bits(`L2_LINE_W, data);
		write_line(addr, data);
		read_and_check("write_hit", addr, cycles);
		compare_value("write_hit", writes_before, u_pmem.write_count);
		finish_test("write_hit");
	endtask

	task automatic test_dirty_eviction();
		lc3b_word addr_a;
		lc3b_burst data;
		int writes_before;
		int cycles;
		addr_a = line_addr(7'd4, 5'd3);
		writes_before = u_pmem.write_count;
		draw_bits(`L2_LINE_W, data);
		write_line(addr_a, data);                       // Installed without a fetch.
		read_and_check("dirty_eviction", line_addr(7'd5, 5'd3), cycles);
		read_and_check("dirty_eviction", line_addr(7'd6, 5'd3), cycles);
		compare_value("dirty_eviction", writes_before + 1, u_pmem.write_count);
		compare_value("dirty_eviction", addr_a, u_pmem.last_write_adr);
		compare_value("dirty_eviction", data, u_pmem.last_write_dat);
		read_and_check("dirty_eviction", addr_a, cycles);
		finish_test("dirty_eviction");
	endtask

	task automatic test_lru();
		int reads_before;
		int writes_before;
		int cycles;
		read_and_check("lru", line_addr(7'd8, 5'd4), cycles);
		read_and_check("lru", line_addr(7'd9, 5'd4), cycles);
		read_and_check("lru", line_addr(7'd8, 5'd4), cycles);
		read_and_check("lru", line_addr(7'd10, 5'd4), cycles);   // Replaces tag 9.
		reads_before = u_pmem.read_count;
		writes_before = u_pmem.write_count;
		read_and_check("lru", line_addr(7'd8, 5'd4), cycles);
		compare_value("lru", reads_before, u_pmem.read_count);
		compare_value("lru", writes_before, u_pmem.write_count);
		read_and_check("lru", line_addr(7'd9, 5'd4), cycles);
		compare_value("lru", reads_before + 1, u_pmem.read_count);
		finish_test("lru");
	endtask

	task automatic test_random();
		lc3b_burst bits;
		lc3b_burst data;
		lc3b_word addr;
		logic we;
		int cycles;
		for (int n = 0; n < RANDOM_COUNT; n++) begin
			draw_bits(1, bits);
			we = bits[0];
			draw_bits(11, bits);
			addr = {2'b10, bits[4:0], 3'b010, bits[6:5], bits[10:7]};   // Tags 64+, sets 8 to 11.
			if (we) begin
				draw_bits(`L2_LINE_W, data);
				write_line(addr, data);
			end else begin
				read_and_check("random", addr, cycles);
			end
		end
		finish_test("random");
	endtask

	// ****************************************
	// Sequence
	// ****************************************

	initial begin
		lfsr_state = 32'h6592;
		errors = 0;
		checks = 0;
		test_errors = 0;
		tests_run = 0;
		reset = 1'b1;
		l1_cyc = 1'b0;
		l1_stb = 1'b0;
		l1_we = 1'b0;
		l1_adr = '0;
		l1_dat_w = '0;
		for (int i = 0; i < NUM_LINES; i++)
			shadow[i] = initial_line(lc3b_word'(i << `L2_OFFSET_W));
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;
		test_reset();
		test_read_hit();
		test_write_hit();
		test_dirty_eviction();
		test_lru();
		test_random();
		$display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule : tb_cache_l2
